//--- verilog/leaf_cfg.svh
`ifndef LEAF_CFG_SVH
`define LEAF_CFG_SVH

// packet field widths.
`define LEAF_PACKET_BITS  49
`define LEAF_PAYLOAD_BITS 32
`define LEAF_LEAF_BITS    5
`define LEAF_PORT_BITS    4
`define LEAF_TAG_BITS     7

// user side of the leaf.
`define LEAF_NUM_IN       7

// words buffered per input port.
`define LEAF_FIFO_DEPTH   4

`define LEAF_ID_DEFAULT   5'd3 // address this leaf answers to.

`endif

//--- verilog/leaf_pkg.sv
`include "leaf_cfg.svh"

package leaf_pkg;

    // filler left over in a configuration packet.
    localparam int unsigned CFG_RSVD_BITS =
        `LEAF_PACKET_BITS - 1 - 2 * `LEAF_LEAF_BITS - 2 * `LEAF_PORT_BITS;

    typedef struct packed {
        logic                          valid;
        logic [`LEAF_LEAF_BITS-1:0]    dest_leaf;
        logic [`LEAF_PORT_BITS-1:0]    dest_port;
        logic [`LEAF_TAG_BITS-1:0]     tag;       // sender sequence number.
        logic [`LEAF_PAYLOAD_BITS-1:0] payload;
    } data_pkt_t;

    // dest_port of zero marks this layout.
    typedef struct packed {
        logic                       valid;
        logic [`LEAF_LEAF_BITS-1:0] dest_leaf;
        logic [`LEAF_PORT_BITS-1:0] dest_port;
        logic [`LEAF_LEAF_BITS-1:0] out_leaf;
        logic [`LEAF_PORT_BITS-1:0] out_port;
        logic [CFG_RSVD_BITS-1:0]   reserved;
    } cfg_pkt_t;

    typedef union packed {
        data_pkt_t data;
        cfg_pkt_t  cfg;
    } packet_u;

    typedef struct packed {
        logic [`LEAF_LEAF_BITS-1:0] leaf;
        logic [`LEAF_PORT_BITS-1:0] port;
    } dest_t;

    typedef struct packed {
        logic                          vld;
        logic [`LEAF_PAYLOAD_BITS-1:0] data;
    } user_word_t;

endpackage

//--- verilog/leaf_rx_decoder.sv
`timescale 1ns/10ps
`include "leaf_cfg.svh"

module leaf_rx_decoder #(
    parameter logic [`LEAF_LEAF_BITS-1:0] LEAF_ID = `LEAF_ID_DEFAULT
) (
    input  logic                          clk_400,
    input  logic                          rst_n,
    input  leaf_pkg::packet_u             pkt_in,
    output logic [`LEAF_NUM_IN-1:0]       wr_en,
    output logic [`LEAF_PAYLOAD_BITS-1:0] wr_data,
    output leaf_pkg::dest_t               dest
);

    logic                    for_us;
    logic                    is_cfg;
    logic [`LEAF_NUM_IN-1:0] port_hit;

    assign for_us = pkt_in.data.valid && (pkt_in.data.dest_leaf == LEAF_ID);
    assign is_cfg = (pkt_in.cfg.dest_port == '0);

    // ports 1..7 map onto strobe bits 0..6, higher ports fall through.
    always_comb begin
        for (int i = 0; i < `LEAF_NUM_IN; i++) begin
            port_hit[i] = for_us && (int'(pkt_in.data.dest_port) == i + 1);
        end
    end

    always_ff @(posedge clk_400) begin
        if (!rst_n) begin
            wr_en <= '0;
            dest  <= '0;
        end else begin
            wr_en <= port_hit;
            if (for_us && is_cfg) begin
                dest.leaf <= pkt_in.cfg.out_leaf; // where our output goes.
                dest.port <= pkt_in.cfg.out_port;
            end
        end
    end

    always_ff @(posedge clk_400) begin
        wr_data <= pkt_in.data.payload;
    end

endmodule

//--- verilog/leaf_in_fifo.sv
`timescale 1ns/10ps
`include "leaf_cfg.svh"

module leaf_in_fifo (
    input  logic                          clk_400,
    input  logic                          rst_n,
    input  logic                          wr_en,
    input  logic [`LEAF_PAYLOAD_BITS-1:0] wr_data,
    output leaf_pkg::user_word_t          user_out,
    input  logic                          ack
);

    localparam int unsigned PTR_BITS = $clog2(`LEAF_FIFO_DEPTH);
    localparam logic [PTR_BITS:0] FULL_COUNT = `LEAF_FIFO_DEPTH;

    logic [`LEAF_PAYLOAD_BITS-1:0] mem [`LEAF_FIFO_DEPTH];
    logic [PTR_BITS-1:0]           wr_ptr;
    logic [PTR_BITS-1:0]           rd_ptr;
    logic [PTR_BITS:0]             count;
    logic [PTR_BITS:0]             count_nxt;
    logic                          not_empty;
    logic                          push;
    logic                          pop;

    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
        ptr_inc = (p == PTR_BITS'(`LEAF_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push = wr_en && (count != FULL_COUNT); // overflow is dropped.
    assign pop  = ack && not_empty;

    assign count_nxt = count + {{PTR_BITS{1'b0}}, push} - {{PTR_BITS{1'b0}}, pop};

    always_ff @(posedge clk_400) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            not_empty <= 1'b0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            count     <= count_nxt;
            not_empty <= (count_nxt != '0);
        end
    end

    always_ff @(posedge clk_400) begin
        if (push) mem[wr_ptr] <= wr_data;
    end

    // head word is offered as long as anything is stored.
    assign user_out.vld  = not_empty;
    assign user_out.data = mem[rd_ptr];

endmodule

//--- verilog/leaf_tx_packer.sv
`timescale 1ns/10ps
`include "leaf_cfg.svh"

module leaf_tx_packer (
    input  logic                 clk_400,
    input  logic                 rst_n,
    input  leaf_pkg::user_word_t user_in,
    output logic                 ack,
    input  leaf_pkg::dest_t      dest,
    input  logic                 resend,
    output leaf_pkg::packet_u    pkt_out
);

    logic [`LEAF_TAG_BITS-1:0] tag;
    logic                      send;
    leaf_pkg::packet_u         pkt_nxt;

    // ack is still high for the word just taken, so skip that cycle.
    assign send = user_in.vld && !resend && !ack;

    always_comb begin
        pkt_nxt                = '0;
        pkt_nxt.data.valid     = 1'b1;
        pkt_nxt.data.dest_leaf = dest.leaf;
        pkt_nxt.data.dest_port = dest.port;
        pkt_nxt.data.tag       = tag;
        pkt_nxt.data.payload   = user_in.data;
    end

    always_ff @(posedge clk_400) begin
        if (!rst_n) begin
            ack     <= 1'b0;
            tag     <= '0;
            pkt_out <= '0;
        end else begin
            ack     <= send;
            pkt_out <= send ? pkt_nxt : '0; // on the wire for one cycle only.
            if (send) begin
                tag <= tag + 1'b1; // wraps at 128.
            end
        end
    end

endmodule

//--- verilog/leaf_interface.sv
`timescale 1ns/10ps
`include "leaf_cfg.svh"

module leaf_interface #(
    parameter logic [`LEAF_LEAF_BITS-1:0] LEAF_ID = `LEAF_ID_DEFAULT
) (
    input  logic                                      clk_400,
    input  logic                                      rst_n,
    input  leaf_pkg::packet_u                         din_leaf_bft2interface,
    output leaf_pkg::packet_u                         dout_leaf_interface2bft,
    input  logic                                      resend,
    input  logic                                      ap_start,
    output logic                                      reset_ap_start_user,
    output leaf_pkg::user_word_t [`LEAF_NUM_IN-1:0]   user_out,
    input  logic [`LEAF_NUM_IN-1:0]                   ack_user2interface,
    input  leaf_pkg::user_word_t                      user_in,
    output logic                                      ack_interface2user
);

    logic [`LEAF_NUM_IN-1:0]       wr_en;
    logic [`LEAF_PAYLOAD_BITS-1:0] wr_data;
    leaf_pkg::dest_t               dest;

    leaf_rx_decoder #(
        .LEAF_ID (LEAF_ID)
    ) i_rx_decoder (
        .clk_400 (clk_400),
        .rst_n   (rst_n),
        .pkt_in  (din_leaf_bft2interface),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .dest    (dest)
    );

    // element n serves network port n+1.
    for (genvar n = 0; n < `LEAF_NUM_IN; n++) begin : g_in_fifo
        leaf_in_fifo i_in_fifo (
            .clk_400  (clk_400),
            .rst_n    (rst_n),
            .wr_en    (wr_en[n]),
            .wr_data  (wr_data),
            .user_out (user_out[n]),
            .ack      (ack_user2interface[n])
        );
    end

    leaf_tx_packer i_tx_packer (
        .clk_400 (clk_400),
        .rst_n   (rst_n),
        .user_in (user_in),
        .ack     (ack_interface2user),
        .dest    (dest),
        .resend  (resend),
        .pkt_out (dout_leaf_interface2bft)
    );

    // low holds the kernel in reset, first ap_start lets it go.
    always_ff @(posedge clk_400) begin
        if (!rst_n) begin
            reset_ap_start_user <= 1'b0;
        end else if (ap_start) begin
            reset_ap_start_user <= 1'b1;
        end
    end

endmodule

//--- verilog/user_kernel.sv
`timescale 1ns/10ps
`include "leaf_cfg.svh"

module user_kernel (
    input  logic                                    clk_400,
    input  logic                                    rst_n,
    input  leaf_pkg::user_word_t [`LEAF_NUM_IN-1:0] user_in,
    output logic [`LEAF_NUM_IN-1:0]                 ack_in,
    output leaf_pkg::user_word_t                    user_out,
    input  logic                                    ack_out
);

    logic                          running;
    logic                          all_vld;
    logic                          take;
    logic [`LEAF_PAYLOAD_BITS-1:0] sum;
    logic                          out_vld;
    logic [`LEAF_PAYLOAD_BITS-1:0] out_data;

    always_comb begin
        all_vld = 1'b1;
        sum     = '0;
        for (int i = 0; i < `LEAF_NUM_IN; i++) begin
            all_vld = all_vld & user_in[i].vld;
            sum     = sum + user_in[i].data; // wrap-around add.
        end
    end

    // one word from every port, and only into a free result register.
    assign take   = running && all_vld && !out_vld;
    assign ack_in = {`LEAF_NUM_IN{take}};

    always_ff @(posedge clk_400) begin
        if (!rst_n) begin
            running <= 1'b0;
            out_vld <= 1'b0;
        end else begin
            running <= 1'b1;
            if (take) begin
                out_vld <= 1'b1;
            end else if (ack_out) begin
                out_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_400) begin
        if (take) out_data <= sum;
    end

    assign user_out.vld  = out_vld;
    assign user_out.data = out_data; // held until ack_out.

endmodule

//--- verilog/leaf_i7o1.sv
`timescale 1ns/10ps
`include "leaf_cfg.svh"

module leaf_i7o1 #(
    parameter logic [`LEAF_LEAF_BITS-1:0] LEAF_ID = `LEAF_ID_DEFAULT
) (
    input  logic              clk_400,
    input  logic              rst_n,
    input  leaf_pkg::packet_u din_leaf_bft2interface,
    output leaf_pkg::packet_u dout_leaf_interface2bft,
    input  logic              resend,
    input  logic              ap_start
);

    leaf_pkg::user_word_t [`LEAF_NUM_IN-1:0] word_interface2user;
    logic [`LEAF_NUM_IN-1:0]                 ack_user2interface;
    leaf_pkg::user_word_t                    word_user2interface;
    logic                                    ack_interface2user;
    logic                                    reset_ap_start_user;
    leaf_pkg::packet_u                       dout_tmp;

    // network must see nothing while it asks for a resend.
    assign dout_leaf_interface2bft = resend ? '0 : dout_tmp;

    leaf_interface #(
        .LEAF_ID (LEAF_ID)
    ) i_leaf_interface (
        .clk_400                 (clk_400),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .dout_leaf_interface2bft (dout_tmp),
        .resend                  (resend),
        .ap_start                (ap_start),
        .reset_ap_start_user     (reset_ap_start_user),
        .user_out                (word_interface2user),
        .ack_user2interface      (ack_user2interface),
        .user_in                 (word_user2interface),
        .ack_interface2user      (ack_interface2user)
    );

    user_kernel i_user_kernel (
        .clk_400  (clk_400),
        .rst_n    (reset_ap_start_user),
        .user_in  (word_interface2user),
        .ack_in   (ack_user2interface),
        .user_out (word_user2interface),
        .ack_out  (ack_interface2user)
    );

endmodule

//--- bench/tb_leaf_i7o1.sv
`timescale 1ns/10ps
`include "leaf_cfg.svh"

module tb_leaf_i7o1;

    localparam logic [`LEAF_LEAF_BITS-1:0] LEAF_ID    = `LEAF_ID_DEFAULT;
    localparam logic [`LEAF_LEAF_BITS-1:0] OTHER_LEAF = LEAF_ID ^ 5'h10;
    localparam int NUM_ROWS  = 6;
    localparam int WRAP_SETS = 124; // pushes the tag past 127 after the table rows.
    localparam int TIMEOUT   = 200;

    typedef struct packed {
        logic [`LEAF_LEAF_BITS-1:0]                      out_leaf;
        logic [`LEAF_PORT_BITS-1:0]                      out_port;
        logic [`LEAF_NUM_IN-1:0][`LEAF_PAYLOAD_BITS-1:0] payload; // port 7 down to port 1.
        logic                                            rnd;
        logic                                            foreign;
        logic [7:0]                                      hold;    // resend cycles.
        logic                                            late;    // ap_start after the data.
    } test_row_t;

    logic              clk_400;
    logic              rst_n;
    logic              resend;
    logic              ap_start;
    leaf_pkg::packet_u din;
    leaf_pkg::packet_u dout;

    test_row_t                 rows [NUM_ROWS];
    leaf_pkg::packet_u         got_q [$];
    logic [`LEAF_TAG_BITS-1:0] exp_tag;
    int                        err_cnt;
    int                        pass_cnt;
    int                        fail_cnt;

    leaf_i7o1 #(
        .LEAF_ID (LEAF_ID)
    ) i_leaf_i7o1 (
        .clk_400                 (clk_400),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout),
        .resend                  (resend),
        .ap_start                (ap_start)
    );

    always #50 clk_400 = ~clk_400;

    // sampled on the falling edge, away from the driving edge.
    always @(negedge clk_400) begin
        if (resend && dout != '0) begin
            $display("FAIL %0t: output word not zero while resend is high", $time);
            err_cnt++;
        end
        if (dout.data.valid) begin
            got_q.push_back(dout);
        end else if (dout != '0) begin
            $display("FAIL %0t: nonzero output word without valid", $time);
            err_cnt++;
        end
    end

    function automatic leaf_pkg::packet_u data_packet(input logic [`LEAF_LEAF_BITS-1:0] leaf,
                                                      input int port,
                                                      input logic [31:0] payload);
        leaf_pkg::packet_u p;
        p                = '0;
        p.data.valid     = 1'b1;
        p.data.dest_leaf = leaf;
        p.data.dest_port = `LEAF_PORT_BITS'(port);
        p.data.payload   = payload;
        return p;
    endfunction

    function automatic leaf_pkg::packet_u cfg_packet(input logic [`LEAF_LEAF_BITS-1:0] leaf,
                                                     input logic [`LEAF_PORT_BITS-1:0] port);
        leaf_pkg::packet_u p;
        p               = '0;
        p.cfg.valid     = 1'b1;
        p.cfg.dest_leaf = LEAF_ID;
        p.cfg.dest_port = '0; // marks a configuration packet.
        p.cfg.out_leaf  = leaf;
        p.cfg.out_port  = port;
        return p;
    endfunction

    function automatic test_row_t make_row(
        input logic [`LEAF_LEAF_BITS-1:0]                      leaf,
        input logic [`LEAF_PORT_BITS-1:0]                      port,
        input logic [`LEAF_NUM_IN-1:0][`LEAF_PAYLOAD_BITS-1:0] payload,
        input logic rnd,
        input logic foreign,
        input logic [7:0] hold,
        input logic late
    );
        test_row_t r;
        r.out_leaf = leaf;
        r.out_port = port;
        r.payload  = payload;
        r.rnd      = rnd;
        r.foreign  = foreign;
        r.hold     = hold;
        r.late     = late;
        return r;
    endfunction

    task automatic drive_packet(input leaf_pkg::packet_u p);
        @(posedge clk_400);
        din <= p;
    endtask

    task automatic end_packets();
        @(posedge clk_400);
        din <= '0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk_400);
    endtask

    task automatic pulse_start();
        @(posedge clk_400);
        ap_start <= 1'b1;
        @(posedge clk_400);
        ap_start <= 1'b0;
    endtask

    task automatic expect_silence(input string what);
        if (got_q.size() != 0) begin
            $display("FAIL %0t: unexpected output packet %s", $time, what);
            err_cnt++;
            got_q.delete();
        end
    endtask

    task automatic check_result(input logic [`LEAF_LEAF_BITS-1:0] leaf,
                                input logic [`LEAF_PORT_BITS-1:0] port,
                                input logic [31:0] sum);
        leaf_pkg::packet_u pkt;
        int                cycles;
        cycles = 0;
        while (got_q.size() == 0 && cycles < TIMEOUT) begin
            @(posedge clk_400);
            cycles++;
        end
        if (got_q.size() == 0) begin
            $display("timeout: no output packet arrived within %0d cycles", TIMEOUT);
            err_cnt++;
        end else begin
            pkt = got_q.pop_front();
            if (pkt.data.dest_leaf != leaf) begin
                $display("FAIL %0t: dest_leaf %0d, expected %0d", $time,
                         pkt.data.dest_leaf, leaf);
                err_cnt++;
            end
            if (pkt.data.dest_port != port) begin
                $display("FAIL %0t: dest_port %0d, expected %0d", $time,
                         pkt.data.dest_port, port);
                err_cnt++;
            end
            if (pkt.data.tag != exp_tag) begin
                $display("FAIL %0t: tag %0d, expected %0d", $time, pkt.data.tag, exp_tag);
                err_cnt++;
            end
            if (pkt.data.payload != sum) begin
                $display("FAIL %0t: payload %h, expected %h", $time, pkt.data.payload, sum);
                err_cnt++;
            end
            exp_tag = exp_tag + 1'b1;
            idle(8);
            expect_silence("after the result"); // exactly one packet per set.
        end
    endtask

    task automatic apply_row(input test_row_t r);
        logic [31:0] pl [`LEAF_NUM_IN];
        logic [31:0] sum;
        sum = '0;
        for (int n = 0; n < `LEAF_NUM_IN; n++) begin
            pl[n] = r.rnd ? $urandom() : r.payload[n];
            sum   = sum + pl[n]; // modulo 2^32.
        end
        expect_silence("before the test");
        drive_packet(cfg_packet(r.out_leaf, r.out_port));
        end_packets();
        if (r.foreign) begin
            for (int n = 0; n < `LEAF_NUM_IN; n++) begin
                drive_packet(data_packet(OTHER_LEAF, n + 1, $urandom()));
            end
            end_packets();
            idle(12);
            expect_silence("for a foreign leaf");
        end
        if (!r.late) pulse_start();
        if (r.hold != 0) begin
            @(posedge clk_400);
            resend <= 1'b1;
        end
        for (int n = 0; n < `LEAF_NUM_IN; n++) begin
            drive_packet(data_packet(LEAF_ID, n + 1, pl[n]));
        end
        end_packets();
        if (r.late) begin
            idle(12);
            expect_silence("before ap_start");
            pulse_start();
        end
        if (r.hold != 0) begin
            idle(r.hold);
            expect_silence("while resend is high");
            @(posedge clk_400);
            resend <= 1'b0;
        end
        check_result(r.out_leaf, r.out_port, sum);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin
        int        errs_before;
        test_row_t wrap_row;
        void'($urandom(32'ha831_1511));
        clk_400  = 1'b0;
        rst_n    = 1'b0;
        resend   = 1'b0;
        ap_start = 1'b0;
        din      = '0;
        exp_tag  = '0;
        err_cnt  = 0;
        pass_cnt = 0;
        fail_cnt = 0;

        // first result, kernel released after the data.
        rows[0] = make_row(5'd2, 4'd5, {32'd700, 32'd600, 32'd500, 32'd400,
                           32'd300, 32'd200, 32'd100}, 1'b0, 1'b0, 8'd0, 1'b1);
        rows[1] = make_row(5'd9, 4'd3, {32'hffff_ffff, 32'h8000_0000, 32'h8000_0000,
                           32'h0000_0001, 32'h1234_5678, 32'hedcb_a987, 32'h0000_0010},
                           1'b0, 1'b0, 8'd0, 1'b0);
        rows[2] = make_row(5'd1, 4'd7, '0, 1'b1, 1'b1, 8'd0, 1'b0);
        rows[3] = make_row(5'd30, 4'd15, {32'hdead_beef, 32'h0, 32'h1, 32'h2,
                           32'h3, 32'h4, 32'h5}, 1'b0, 1'b0, 8'd20, 1'b0);
        rows[4] = make_row(5'd17, 4'd2, '0, 1'b1, 1'b1, 8'd6, 1'b0);
        rows[5] = make_row(5'd0, 4'd1, '0, 1'b1, 1'b0, 8'd0, 1'b0);

        repeat (10) @(posedge clk_400);
        rst_n <= 1'b1;
        idle(2);
        expect_silence("after reset");

        for (int t = 0; t < NUM_ROWS; t++) begin
            errs_before = err_cnt;
            apply_row(rows[t]);
            report_test($sformatf("row %0d", t), errs_before);
        end

        errs_before = err_cnt;
        for (int s = 0; s < WRAP_SETS; s++) begin
            wrap_row = make_row(5'(s), 4'(s % 15 + 1), '0, 1'b1, 1'b0, 8'd0, 1'b0);
            apply_row(wrap_row);
        end
        report_test("tag wrap", errs_before);

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- leaf_i7o1.f
+incdir+verilog
verilog/leaf_pkg.sv
verilog/leaf_rx_decoder.sv
verilog/leaf_in_fifo.sv
verilog/leaf_tx_packer.sv
verilog/leaf_interface.sv
verilog/user_kernel.sv
verilog/leaf_i7o1.sv
bench/tb_leaf_i7o1.sv

//--- Bender.yml
package:
  name: leaf_i7o1

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/leaf_pkg.sv
      - verilog/leaf_rx_decoder.sv
      - verilog/leaf_in_fifo.sv
      - verilog/leaf_tx_packer.sv
      - verilog/leaf_interface.sv
      - verilog/user_kernel.sv
      - verilog/leaf_i7o1.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_leaf_i7o1.sv
